//--- logic/ecfg_pkg.sv
// shared address map, reset values and types of the elink config block
// word index is mi_addr[7:2] and word index bit 3 picks the rx region
// only word indices 0 to 15 are mapped
`default_nettype none

package ecfg_pkg;

   // ##################################################
   // widths that carry a meaning
   // ##################################################
   typedef logic [7:0]  mi_addr_t;   // byte address, bits 1:0 ignored
   typedef logic [31:0] mi_data_t;
   typedef logic [2:0]  reg_idx_t;   // register within a region
   typedef logic [11:0] chipid_t;
   typedef logic [3:0]  ctrlmode_t;  // emesh ctrlmode tag
   typedef logic [8:0]  gpio_t;
   typedef logic [15:0] status_t;    // low bits sticky

   localparam int TX_CFG_W = 11;
   localparam int RX_CFG_W = 7;
   localparam int STICKY_W = 3;      // sticky low status bits

   // word index address map
   localparam logic [5:0] ETX_CFG    = 6'd0;
   localparam logic [5:0] ETX_STATUS = 6'd1;
   localparam logic [5:0] ETX_GPIO   = 6'd2;
   localparam logic [5:0] E_CHIPID   = 6'd3;
   localparam logic [5:0] E_VERSION  = 6'd4;   // read only
   localparam logic [5:0] ERX_CFG    = 6'd8;
   localparam logic [5:0] ERX_STATUS = 6'd9;
   localparam logic [5:0] ERX_GPIO   = 6'd10;  // read only
   localparam logic [5:0] ERX_OFFSET = 6'd11;

   localparam chipid_t DEFAULT_CHIPID = 12'h808;
   localparam logic [15:0] ECFG_VERSION = 16'h0102;

   // mode field encodings
   localparam logic [1:0] REMAP_ON = 2'b01;
   localparam logic [1:0] OUT_GPIO = 2'b01;
   localparam logic [1:0] OUT_TP   = 2'b10;   // 1/0 test pattern

   // one access as one register file sees it
   typedef struct packed {
      logic     en;
      logic     we;
      reg_idx_t idx;
      mi_data_t din;
   } mi_req_t;

   typedef struct packed {
      logic      tx_enable;
      logic      mmu_enable;
      logic      remap_enable;
      ctrlmode_t ctrlmode;
      logic      ctrlmode_bypass;
      logic      gpio_enable;      // tx pins forced to gpio_data
      logic      tp_enable;
      gpio_t     gpio_data;
      chipid_t   chipid;
   } tx_ctrl_t;

   typedef struct packed {
      logic       rx_enable;
      logic       mmu_enable;
      logic       remap_enable;
      logic [1:0] filter_mode;
      logic       test_mode;
      mi_data_t   remap_offset;
   } rx_ctrl_t;

   // set wins over a write-one clear in the same cycle
   function automatic logic [STICKY_W-1:0] sticky_next(input logic [STICKY_W-1:0] cur,
                                                       input logic [STICKY_W-1:0] set,
                                                       input logic [STICKY_W-1:0] clr);
      return (cur & ~clr) | set;
   endfunction

endpackage

`default_nettype wire

//--- logic/ecfg_mi_merge.sv
// region decode and read reply merge for the mi port
// word indices 16 and up reach neither register file and read zero
`timescale 1ns/1ps
`default_nettype none

module ecfg_mi_merge (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 mi_en,      // single cycle strobe
   input  wire                 mi_we,
   input  wire ecfg_pkg::mi_addr_t  mi_addr,
   input  wire ecfg_pkg::mi_data_t  mi_din,
   output ecfg_pkg::mi_req_t   tx_req,
   output ecfg_pkg::mi_req_t   rx_req,
   input  wire ecfg_pkg::mi_data_t  tx_rd_data,
   input  wire ecfg_pkg::mi_data_t  rx_rd_data,
   output ecfg_pkg::mi_data_t  mi_dout,
   output logic                mi_rvalid
);

   import ecfg_pkg::*;

   logic [5:0] word_idx;
   logic       in_map;   // word index 0 to 15
   logic       is_rx;    // region bit

   assign word_idx = mi_addr[7:2];
   assign in_map   = (word_idx[5:4] == 2'b00);
   assign is_rx    = (word_idx[3] == ERX_CFG[3]);

   // same payload to both, en picks the region
   always_comb begin
      tx_req     = '0;
      tx_req.en  = mi_en & in_map & ~is_rx;
      tx_req.we  = mi_we;
      tx_req.idx = word_idx[2:0];
      tx_req.din = mi_din;
      rx_req     = tx_req;
      rx_req.en  = mi_en & in_map & is_rx;
   end

   // every read answers one cycle later, mapped or not
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mi_rvalid <= 1'b0;
      end else begin
         mi_rvalid <= mi_en & ~mi_we;
      end
   end

   assign mi_dout = tx_rd_data | rx_rd_data;  // idle side is zero

endmodule

`default_nettype wire

//--- logic/ecfg_tx.sv
// tx register file, req.en must only be set for tx region accesses
// version reads ECFG_VERSION and ignores writes
// rd_data is zero in every cycle not following a read
`timescale 1ns/1ps
`default_nettype none

module ecfg_tx (
   input  wire                clk,
   input  wire                reset,
   input  wire ecfg_pkg::mi_req_t  req,        // tx region access
   input  wire ecfg_pkg::status_t  tx_status,  // live etx status
   output ecfg_pkg::mi_data_t rd_data,         // registered reply
   output ecfg_pkg::tx_ctrl_t tx_ctrl
);

   import ecfg_pkg::*;

   logic [TX_CFG_W-1:0] cfg_q;
   gpio_t               gpio_q;
   chipid_t             chipid_q;
   logic [STICKY_W-1:0] sticky_q;
   logic [STICKY_W-1:0] sticky_clr;

   logic wr_en;
   logic rd_en;
   logic wr_cfg;
   logic wr_status;
   logic wr_gpio;
   logic wr_chipid;

   // ##################################################
   // write decode
   // ##################################################
   assign wr_en = req.en & req.we;
   assign rd_en = req.en & ~req.we;

   assign wr_cfg    = wr_en & (req.idx == ETX_CFG[2:0]);
   assign wr_status = wr_en & (req.idx == ETX_STATUS[2:0]);
   assign wr_gpio   = wr_en & (req.idx == ETX_GPIO[2:0]);
   assign wr_chipid = wr_en & (req.idx == E_CHIPID[2:0]);

   // ones written to status clear sticky bits
   assign sticky_clr = wr_status ? req.din[STICKY_W-1:0] : '0;

   // ##################################################
   // registers
   // ##################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg_q    <= '0;
         gpio_q   <= '0;
         chipid_q <= DEFAULT_CHIPID;
         sticky_q <= '0;
      end else begin
         if (wr_cfg) begin
            cfg_q <= req.din[TX_CFG_W-1:0];
         end
         if (wr_gpio) begin
            gpio_q <= gpio_t'(req.din);  // low 9 bits
         end
         if (wr_chipid) begin
            chipid_q <= chipid_t'(req.din);
         end
         sticky_q <= sticky_next(sticky_q, tx_status[STICKY_W-1:0], sticky_clr);
      end
   end

   // field decode of the config word
   always_comb begin
      tx_ctrl                 = '0;
      tx_ctrl.tx_enable       = cfg_q[0];
      tx_ctrl.mmu_enable      = cfg_q[1];
      tx_ctrl.remap_enable    = (cfg_q[3:2] == REMAP_ON);
      tx_ctrl.ctrlmode        = cfg_q[7:4];
      tx_ctrl.ctrlmode_bypass = cfg_q[8];
      tx_ctrl.gpio_enable     = (cfg_q[10:9] == OUT_GPIO);
      tx_ctrl.tp_enable       = (cfg_q[10:9] == OUT_TP);  // 11 drives neither
      tx_ctrl.gpio_data       = gpio_q;
      tx_ctrl.chipid          = chipid_q;
   end

   // ##################################################
   // readback mux, one cycle latency
   // ##################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_data <= '0;
      end else if (rd_en) begin
         case (req.idx)
            ETX_CFG[2:0]: begin
               rd_data <= mi_data_t'(cfg_q);
            end
            ETX_STATUS[2:0]: begin
               // upper bits read live
               rd_data <= mi_data_t'({tx_status[15:STICKY_W], sticky_q});
            end
            ETX_GPIO[2:0]:  rd_data <= mi_data_t'(gpio_q);
            E_CHIPID[2:0]:  rd_data <= mi_data_t'(chipid_q);
            E_VERSION[2:0]: rd_data <= mi_data_t'(ECFG_VERSION);
            default:        rd_data <= '0;  // unmapped
         endcase
      end else begin
         rd_data <= '0;  // keeps the merge OR clean
      end
   end

endmodule

`default_nettype wire

//--- logic/ecfg_rx.sv
// rx register file, req.en must only be set for rx region accesses
// gpio register reads rx_gpio as sampled one cycle earlier, writes ignored
`timescale 1ns/1ps
`default_nettype none

module ecfg_rx (
   input  wire                clk,
   input  wire                reset,
   input  wire ecfg_pkg::mi_req_t  req,        // rx region access
   input  wire ecfg_pkg::status_t  rx_status,  // live erx status
   input  wire ecfg_pkg::gpio_t    rx_gpio,    // rx pins
   output ecfg_pkg::mi_data_t rd_data,
   output ecfg_pkg::rx_ctrl_t rx_ctrl
);

   import ecfg_pkg::*;

   logic [RX_CFG_W-1:0] cfg_q;
   mi_data_t            offset_q;   // remap offset
   logic [STICKY_W-1:0] sticky_q;
   logic [STICKY_W-1:0] sticky_clr;
   gpio_t               gpio_q;     // pin sample

   logic wr_en;
   logic rd_en;
   logic wr_cfg;
   logic wr_status;
   logic wr_offset;

   // ##################################################
   // write decode
   // ##################################################
   assign wr_en = req.en & req.we;
   assign rd_en = req.en & ~req.we;

   assign wr_cfg    = wr_en & (req.idx == ERX_CFG[2:0]);
   assign wr_status = wr_en & (req.idx == ERX_STATUS[2:0]);
   assign wr_offset = wr_en & (req.idx == ERX_OFFSET[2:0]);

   assign sticky_clr = wr_status ? req.din[STICKY_W-1:0] : '0;

   // ##################################################
   // registers
   // ##################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg_q    <= '0;
         offset_q <= '0;
         sticky_q <= '0;
      end else begin
         if (wr_cfg) begin
            cfg_q <= req.din[RX_CFG_W-1:0];
         end
         if (wr_offset) begin
            offset_q <= req.din;  // full 32 bits
         end
         sticky_q <= sticky_next(sticky_q, rx_status[STICKY_W-1:0], sticky_clr);
      end
   end

   // free running pin sample
   always_ff @(posedge clk) begin
      gpio_q <= rx_gpio;
   end

   always_comb begin
      rx_ctrl              = '0;
      rx_ctrl.rx_enable    = cfg_q[0];
      rx_ctrl.mmu_enable   = cfg_q[1];
      rx_ctrl.remap_enable = (cfg_q[3:2] == REMAP_ON);
      rx_ctrl.filter_mode  = cfg_q[5:4];
      rx_ctrl.test_mode    = cfg_q[6];
      rx_ctrl.remap_offset = offset_q;
   end

   // ##################################################
   // readback mux, one cycle latency
   // ##################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_data <= '0;
      end else if (rd_en) begin
         case (req.idx)
            ERX_CFG[2:0]: begin
               rd_data <= mi_data_t'(cfg_q);
            end
            ERX_STATUS[2:0]: begin
               rd_data <= mi_data_t'({rx_status[15:STICKY_W], sticky_q});
            end
            ERX_GPIO[2:0]:   rd_data <= mi_data_t'(gpio_q);
            ERX_OFFSET[2:0]: rd_data <= offset_q;
            default:         rd_data <= '0;
         endcase
      end else begin
         rd_data <= '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/ecfg_top.sv
// elink config block top with tx and rx register files behind one mi port
// no back-pressure, each read replies exactly one cycle after its strobe
`timescale 1ns/1ps
`default_nettype none

module ecfg_top (
   input  wire                 clk,
   input  wire                 reset,
   // mi port
   input  wire                 mi_en,
   input  wire                 mi_we,
   input  wire ecfg_pkg::mi_addr_t  mi_addr,
   input  wire ecfg_pkg::mi_data_t  mi_din,
   output ecfg_pkg::mi_data_t  mi_dout,
   output logic                mi_rvalid,
   // elink control and status
   output ecfg_pkg::tx_ctrl_t  tx_ctrl,
   output ecfg_pkg::rx_ctrl_t  rx_ctrl,
   input  wire ecfg_pkg::status_t   tx_status,
   input  wire ecfg_pkg::status_t   rx_status,
   input  wire ecfg_pkg::gpio_t     rx_gpio
);

   import ecfg_pkg::*;

   mi_req_t  tx_req;
   mi_req_t  rx_req;
   mi_data_t tx_rd_data;
   mi_data_t rx_rd_data;

   ecfg_mi_merge u_merge (
      .clk        (clk),
      .reset      (reset),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .tx_req     (tx_req),
      .rx_req     (rx_req),
      .tx_rd_data (tx_rd_data),
      .rx_rd_data (rx_rd_data),
      .mi_dout    (mi_dout),
      .mi_rvalid  (mi_rvalid)
   );

   ecfg_tx u_tx (
      .clk       (clk),
      .reset     (reset),
      .req       (tx_req),
      .tx_status (tx_status),
      .rd_data   (tx_rd_data),
      .tx_ctrl   (tx_ctrl)
   );

   ecfg_rx u_rx (
      .clk       (clk),
      .reset     (reset),
      .req       (rx_req),
      .rx_status (rx_status),
      .rx_gpio   (rx_gpio),
      .rd_data   (rx_rd_data),
      .rx_ctrl   (rx_ctrl)
   );

endmodule

`default_nettype wire

//--- tb/ecfg_sva.sv
// concurrent checks on the mi read reply and the reset state of ecfg_top
// bound into every ecfg_top instance
`timescale 1ns/1ps
`default_nettype none

module ecfg_sva (
   input wire                      clk,
   input wire                      reset,
   input wire                      mi_en,
   input wire                      mi_we,
   input wire ecfg_pkg::mi_data_t  mi_dout,
   input wire                      mi_rvalid,
   input wire ecfg_pkg::tx_ctrl_t  tx_ctrl,
   input wire ecfg_pkg::rx_ctrl_t  rx_ctrl
);

   import ecfg_pkg::*;

   // chipid is the lowest field of tx_ctrl
   localparam tx_ctrl_t TX_CTRL_RESET = tx_ctrl_t'({19'd0, DEFAULT_CHIPID});

   // reply on the cycle right after each read strobe
   a_read_reply: assert property (@(posedge clk) disable iff (reset)
      (mi_en && !mi_we) |=> mi_rvalid)
      else $error("read strobe got no reply on the next cycle");

   // and never without one
   a_no_stray_reply: assert property (@(posedge clk) disable iff (reset)
      !(mi_en && !mi_we) |=> !mi_rvalid)
      else $error("read reply without a read strobe");

   a_idle_dout: assert property (@(posedge clk)
      !mi_rvalid |-> (mi_dout == '0))
      else $error("mi_dout not zero while mi_rvalid is low");

   a_reset_state: assert property (@(posedge clk)
      reset |-> (!mi_rvalid && mi_dout == '0 && tx_ctrl == TX_CTRL_RESET
                 && rx_ctrl == '0))
      else $error("outputs left their reset values during reset");

endmodule

bind ecfg_top ecfg_sva u_sva (
   .clk       (clk),
   .reset     (reset),
   .mi_en     (mi_en),
   .mi_we     (mi_we),
   .mi_dout   (mi_dout),
   .mi_rvalid (mi_rvalid),
   .tx_ctrl   (tx_ctrl),
   .rx_ctrl   (rx_ctrl)
);

`default_nettype wire

//--- tb/ecfg_tb.sv
// self-checking testbench for ecfg_top that stops at the first mismatch
// reference model follows the mi writes and the status inputs cycle by cycle
`timescale 1ns/1ps
`default_nettype none

module ecfg_tb;

   import ecfg_pkg::*;

   localparam int TIMEOUT = 20;   // cycles allowed per wait
   localparam int BURST_N = 10;

   logic     clk;
   logic     reset;
   logic     mi_en;
   logic     mi_we;
   mi_addr_t mi_addr;
   mi_data_t mi_din;
   mi_data_t mi_dout;
   logic     mi_rvalid;
   tx_ctrl_t tx_ctrl;
   rx_ctrl_t rx_ctrl;
   status_t  tx_status;
   status_t  rx_status;
   gpio_t    rx_gpio;

   logic [31:0] rng;                       // xorshift state
   logic [5:0]  burst_words [BURST_N];
   logic [5:0]  writable_words [5];

   // reference model of every register
   logic [10:0] m_tx_cfg;
   gpio_t       m_tx_gpio;
   chipid_t     m_chipid;
   logic [2:0]  m_tx_sticky;
   logic [6:0]  m_rx_cfg;
   mi_data_t    m_rx_offset;
   logic [2:0]  m_rx_sticky;
   gpio_t       m_rx_gpio;                 // pins one cycle back

   ecfg_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .mi_en     (mi_en),
      .mi_we     (mi_we),
      .mi_addr   (mi_addr),
      .mi_din    (mi_din),
      .mi_dout   (mi_dout),
      .mi_rvalid (mi_rvalid),
      .tx_ctrl   (tx_ctrl),
      .rx_ctrl   (rx_ctrl),
      .tx_status (tx_status),
      .rx_status (rx_status),
      .rx_gpio   (rx_gpio)
   );

   always #50 clk = ~clk;  // 100 ns period

   // ##################################################
   // helpers
   // ##################################################
   function automatic logic [31:0] rnd();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // byte address of a word with random ignored low bits
   function automatic mi_addr_t word_addr(input logic [5:0] word);
      logic [31:0] r;
      r = rnd();
      return {word, r[1:0]};
   endfunction

   // write one clear mask seen by a status register this cycle
   function automatic logic [2:0] clear_bits(input logic [5:0] word);
      if (mi_en && mi_we && mi_addr[7:2] == word) begin
         return mi_din[2:0];
      end
      return 3'b000;
   endfunction

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         m_tx_cfg    <= '0;
         m_tx_gpio   <= '0;
         m_chipid    <= 12'h808;
         m_tx_sticky <= '0;
         m_rx_cfg    <= '0;
         m_rx_offset <= '0;
         m_rx_sticky <= '0;
         m_rx_gpio   <= '0;
      end else begin
         m_rx_gpio   <= rx_gpio;
         // a bit set this cycle survives its own clear
         m_tx_sticky <= (m_tx_sticky & ~clear_bits(ETX_STATUS)) | tx_status[2:0];
         m_rx_sticky <= (m_rx_sticky & ~clear_bits(ERX_STATUS)) | rx_status[2:0];
         if (mi_en && mi_we) begin
            case (mi_addr[7:2])
               ETX_CFG:    m_tx_cfg    <= mi_din[10:0];
               ETX_GPIO:   m_tx_gpio   <= mi_din[8:0];
               E_CHIPID:   m_chipid    <= mi_din[11:0];
               ERX_CFG:    m_rx_cfg    <= mi_din[6:0];
               ERX_OFFSET: m_rx_offset <= mi_din;
               default: ;  // read only or unmapped
            endcase
         end
      end
   end

   function automatic mi_data_t expect_read(input mi_addr_t addr);
      case (addr[7:2])
         ETX_CFG:    return {21'd0, m_tx_cfg};
         ETX_STATUS: return {16'd0, tx_status[15:3], m_tx_sticky};  // upper live
         ETX_GPIO:   return {23'd0, m_tx_gpio};
         E_CHIPID:   return {20'd0, m_chipid};
         E_VERSION:  return 32'h0000_0102;
         ERX_CFG:    return {25'd0, m_rx_cfg};
         ERX_STATUS: return {16'd0, rx_status[15:3], m_rx_sticky};
         ERX_GPIO:   return {23'd0, m_rx_gpio};
         ERX_OFFSET: return m_rx_offset;
         default:    return 32'd0;
      endcase
   endfunction

   function automatic tx_ctrl_t expect_tx_ctrl();
      tx_ctrl_t c;
      c.tx_enable       = m_tx_cfg[0];
      c.mmu_enable      = m_tx_cfg[1];
      c.remap_enable    = (m_tx_cfg[3:2] == 2'b01);
      c.ctrlmode        = m_tx_cfg[7:4];
      c.ctrlmode_bypass = m_tx_cfg[8];
      c.gpio_enable     = (m_tx_cfg[10:9] == 2'b01);
      c.tp_enable       = (m_tx_cfg[10:9] == 2'b10);
      c.gpio_data       = m_tx_gpio;
      c.chipid          = m_chipid;
      return c;
   endfunction

   function automatic rx_ctrl_t expect_rx_ctrl();
      rx_ctrl_t c;
      c.rx_enable    = m_rx_cfg[0];
      c.mmu_enable   = m_rx_cfg[1];
      c.remap_enable = (m_rx_cfg[3:2] == 2'b01);
      c.filter_mode  = m_rx_cfg[5:4];
      c.test_mode    = m_rx_cfg[6];
      c.remap_offset = m_rx_offset;
      return c;
   endfunction

   task automatic stop_failed(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         stop_failed($sformatf("error %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic check_ctrl(input string name);
      tx_ctrl_t tx_exp;
      rx_ctrl_t rx_exp;
      tx_exp = expect_tx_ctrl();
      rx_exp = expect_rx_ctrl();
      assert (tx_ctrl === tx_exp) else begin
         stop_failed($sformatf("error %s tx_ctrl expected %h actual %h", name, tx_exp, tx_ctrl));
      end
      assert (rx_ctrl === rx_exp) else begin
         stop_failed($sformatf("error %s rx_ctrl expected %h actual %h", name, rx_exp, rx_ctrl));
      end
   endtask

   // ##################################################
   // mi accesses driven on the falling edge
   // ##################################################
   task automatic write_reg(input mi_addr_t addr, input mi_data_t data);
      @(negedge clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = data;
      @(negedge clk);
      mi_en = 1'b0;
      mi_we = 1'b0;
   endtask

   task automatic read_check(input string name, input logic [5:0] word);
      mi_data_t expected;
      int       waited;
      @(negedge clk);
      mi_addr  = word_addr(word);
      expected = expect_read(mi_addr);  // state the DUT sees at the strobe
      mi_en    = 1'b1;
      mi_we    = 1'b0;
      mi_din   = rnd();
      @(negedge clk);
      mi_en  = 1'b0;
      waited = 0;
      while (!mi_rvalid && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!mi_rvalid) begin
         stop_failed($sformatf("no read reply arrived for %s", name));
      end
      check_value(name, expected, mi_dout);
   endtask

   // one strobe per cycle with each reply due on the next cycle
   task automatic read_burst(input string name);
      mi_data_t prev_exp;
      prev_exp = '0;
      for (int i = 0; i <= BURST_N; i++) begin
         @(negedge clk);
         if (i > 0) begin
            assert (mi_rvalid) else begin
               stop_failed($sformatf("%s reply %0d was not on the next cycle", name, i - 1));
            end
            check_value(name, prev_exp, mi_dout);
         end
         if (i < BURST_N) begin
            mi_addr  = word_addr(burst_words[i]);
            prev_exp = expect_read(mi_addr);
            mi_en    = 1'b1;
            mi_we    = 1'b0;
         end else begin
            mi_en = 1'b0;
         end
      end
   endtask

   // ##################################################
   // stimulus
   // ##################################################
   initial begin
      logic [31:0] r;
      int          idx;
      clk       = 1'b0;
      reset     = 1'b0;
      mi_en     = 1'b0;
      mi_we     = 1'b0;
      mi_addr   = '0;
      mi_din    = '0;
      tx_status = '0;
      rx_status = '0;
      rx_gpio   = '0;
      rng       = 32'hf30a_a573;
      // alternating regions with unmapped words mixed in
      burst_words = '{ETX_CFG, ERX_OFFSET, E_CHIPID, ERX_CFG, 6'd5,
                      6'd13, ETX_GPIO, 6'd20, ERX_GPIO, 6'd63};
      writable_words = '{ETX_CFG, ETX_GPIO, E_CHIPID, ERX_CFG, ERX_OFFSET};
      #1 reset = 1'b1;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      check_ctrl("reset_ctrl");
      read_check("reset_version", E_VERSION);
      read_check("reset_chipid", E_CHIPID);

      // every remap and output mode code on both sides
      for (int k = 0; k < 4; k++) begin
         r = rnd();
         write_reg(word_addr(ETX_CFG), {r[31:11], k[1:0], r[8:4], k[1:0], r[1:0]});
         r = rnd();
         write_reg(word_addr(ERX_CFG), {r[31:4], k[1:0], r[1:0]});
         check_ctrl("mode_ctrl");
         read_check("mode_tx_cfg", ETX_CFG);
         read_check("mode_rx_cfg", ERX_CFG);
      end
      for (int n = 0; n < 40; n++) begin
         r   = rnd();
         idx = int'(r % 5);
         write_reg(word_addr(writable_words[idx]), rnd());
         check_ctrl("random_ctrl");
         read_check("random_rw", writable_words[idx]);
      end

      read_burst("back_to_back");

      // sticky status pulses then clears
      @(negedge clk);
      r = rnd();
      tx_status = {r[15:3], 3'b101};
      rx_status = {r[31:19], 3'b010};
      @(negedge clk);
      tx_status[2:0] = 3'b000;
      rx_status[2:0] = 3'b000;
      read_check("tx_sticky_set", ETX_STATUS);
      read_check("rx_sticky_set", ERX_STATUS);
      tx_status[15:3] = r[28:16];  // upper bits follow the pins
      read_check("tx_status_live", ETX_STATUS);
      write_reg(word_addr(ETX_STATUS), 32'h0000_0001);
      write_reg(word_addr(ERX_STATUS), 32'h0000_0004);  // bit 1 stays
      read_check("tx_sticky_clr", ETX_STATUS);
      read_check("rx_sticky_clr", ERX_STATUS);
      tx_status[1] = 1'b1;                               // set beats clear
      write_reg(word_addr(ETX_STATUS), 32'h0000_0006);
      tx_status[1] = 1'b0;
      read_check("tx_set_vs_clr", ETX_STATUS);
      write_reg(word_addr(ETX_STATUS), 32'h0000_0007);
      write_reg(word_addr(ERX_STATUS), 32'h0000_0007);
      read_check("tx_sticky_empty", ETX_STATUS);
      read_check("rx_sticky_empty", ERX_STATUS);

      // read only registers
      write_reg(word_addr(E_VERSION), rnd());
      read_check("version_ro", E_VERSION);
      for (int n = 0; n < 8; n++) begin
         r = rnd();
         @(negedge clk);
         rx_gpio = r[8:0];
         @(negedge clk);
         // write strobe in the cycle right before the read strobe
         mi_en   = 1'b1;
         mi_we   = 1'b1;
         mi_addr = word_addr(ERX_GPIO);
         mi_din  = rnd();
         read_check("rx_gpio_ro", ERX_GPIO);  // pins held two cycles by now
      end
      check_ctrl("final_ctrl");

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- ecfg.f
logic/ecfg_pkg.sv
logic/ecfg_mi_merge.sv
logic/ecfg_tx.sv
logic/ecfg_rx.sv
logic/ecfg_top.sv
tb/ecfg_sva.sv
tb/ecfg_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the ecfg testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module ecfg_tb --Mdir "$BUILD" -o ecfg_sim -f ecfg.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"$BUILD"/ecfg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
